//--- bayer_blc_top.f
hw/bayer_blc_pkg.sv
hw/bayer_blc_regs.sv
hw/bayer_blc_core.sv
hw/bayer_blc_top.sv
dv/blc_clk_gen.sv
dv/bayer_blc_tb.sv

//--- dv/bayer_blc_tb.sv
// ----------------------------------------------------------------------
// black level subsystem testbench with APB register access and 8x4
// frames checked against a reference queue, cke dropped at random.
// inputs change on the falling edge, checks sample on the rising edge
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bayer_blc_tb
    import bayer_blc_pkg::*;
();

    localparam int FRAME_W = 8;
    localparam int FRAME_H = 4;

    logic                     s_img;
    logic                     rst;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_DATA_BITS-1:0] pwdata;
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     cke;
    logic                     in_valid;
    logic                     in_row_first;
    logic                     in_row_last;
    logic                     in_col_first;
    logic                     in_col_last;
    logic                     in_de;
    logic [USER_BITS-1:0]     in_user;
    logic [PIX_BITS-1:0]      in_data;
    logic                     out_valid;
    logic                     out_row_first;
    logic                     out_row_last;
    logic                     out_col_first;
    logic                     out_col_last;
    logic                     out_de;
    logic [USER_BITS-1:0]     out_user;
    logic [OUT_BITS-1:0]      out_data;
    logic [5:0]               out_side;

    // beat layout {user, row_first, row_last, col_first, col_last, de, data}
    logic [15:0]              pend_beat;
    logic [15:0]              exp_q[$];
    int                       stamp_q[$];
    logic                     head_valid;
    logic [15:0]              head_beat;
    int                       head_stamp;
    int                       en_cycle;
    logic                     prev_cke;
    logic                     prev_valid;
    logic [OUT_BITS-1:0]      prev_data;

    // software view of the live and shadow settings
    logic                     m_en;
    logic [1:0]               m_ph;
    logic [9:0]               m_off [4];
    logic                     m_sh_en;
    logic [1:0]               m_sh_ph;
    logic [9:0]               m_sh_off [4];

    blc_clk_gen clk_rst (.s_img(s_img), .rst(rst));

    bayer_blc_top DUT (.*);

    assign out_side = {out_user, out_row_first, out_row_last, out_col_first, out_col_last, out_de};

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic reg_mapped(input logic [11:0] addr);
        case (addr)
            ADDR_CTRL, ADDR_OFFSET0, ADDR_OFFSET1, ADDR_OFFSET2, ADDR_OFFSET3: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_reg(input logic [11:0] addr);
        case (addr)
            ADDR_CTRL:    return {29'd0, m_ph, m_en};
            ADDR_OFFSET0: return {22'd0, m_off[0]};
            ADDR_OFFSET1: return {22'd0, m_off[1]};
            ADDR_OFFSET2: return {22'd0, m_off[2]};
            ADDR_OFFSET3: return {22'd0, m_off[3]};
            default:      return 32'd0;
        endcase
    endfunction

    function automatic logic [11:0] offset_addr(input int i);
        return ADDR_OFFSET0 + 12'(4 * i);
    endfunction

    // site index is {row parity, column parity} xored with the start phase
    function automatic logic [9:0] expect_pixel(input logic [9:0] d, input int r, input int c);
        logic [1:0] site;
        site = {r[0] ^ m_sh_ph[1], c[0] ^ m_sh_ph[0]};
        if (!m_sh_en) return d;
        if (d < m_sh_off[site]) return 10'd0;
        return d - m_sh_off[site];
    endfunction

    // ------------------------------------------------------------------
    // APB
    // ------------------------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        @(negedge s_img);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge s_img);
        penable = 1'b1;
        n = 0;
        @(posedge s_img);
        while (!pready && n < 16) begin
            n++;
            @(posedge s_img);
        end
        if (!pready) stop_on_error("APB transfer never saw pready");
        rdata = prdata;
        err   = pslverr;
        @(negedge s_img);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        logic        exp_err;
        exp_err = !reg_mapped(addr);
        apb_xfer(1'b1, addr, wdata, rd, err);
        assert (err == exp_err)
            else stop_on_error($sformatf("Error at %0t: pslverr got %0b expected %0b",
                                         $time, err, exp_err));
        case (addr)
            ADDR_CTRL: begin
                m_en = wdata[0];
                m_ph = wdata[2:1];
            end
            ADDR_OFFSET0: m_off[0] = wdata[9:0];
            ADDR_OFFSET1: m_off[1] = wdata[9:0];
            ADDR_OFFSET2: m_off[2] = wdata[9:0];
            ADDR_OFFSET3: m_off[3] = wdata[9:0];
            default: ;
        endcase
    endtask

    task automatic check_read(input logic [11:0] addr);
        logic [31:0] rd;
        logic        err;
        logic        exp_err;
        exp_err = !reg_mapped(addr);
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        assert (err == exp_err)
            else stop_on_error($sformatf("Error at %0t: pslverr got %0b expected %0b",
                                         $time, err, exp_err));
        assert (rd == model_reg(addr))
            else stop_on_error($sformatf("Error at %0t: prdata got %h expected %h",
                                         $time, rd, model_reg(addr)));
    endtask

    task automatic set_offsets(input int base, input int step);
        int i;
        for (i = 0; i < 4; i++) begin
            apb_write(offset_addr(i), 32'hfc00_0000 | 32'(base + step * i));
        end
    endtask

    // ------------------------------------------------------------------
    // pixel stimulus
    // ------------------------------------------------------------------
    task automatic send_frame(input bit stall, input int dmax);
        int         r;
        int         c;
        int         k;
        int         n_stall;
        logic [9:0] d;
        for (r = 0; r < FRAME_H; r++) begin
            for (c = 0; c < FRAME_W; c++) begin
                @(negedge s_img);
                if (r == 0 && c == 0) begin
                    m_sh_en  = m_en;
                    m_sh_ph  = m_ph;
                    m_sh_off = m_off;
                end
                d            = 10'($urandom_range(dmax, 0));
                in_valid     = 1'b1;
                in_row_first = (r == 0);
                in_row_last  = (r == FRAME_H - 1);
                in_col_first = (c == 0);
                in_col_last  = (c == FRAME_W - 1);
                in_de        = 1'($urandom);
                in_user      = 1'($urandom);
                in_data      = d;
                pend_beat    = {in_user, in_row_first, in_row_last, in_col_first, in_col_last,
                                in_de, expect_pixel(d, r, c)};
                n_stall = (stall && $urandom_range(2, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
                for (k = 0; k < n_stall; k++) begin
                    cke = 1'b0;
                    @(negedge s_img);
                end
                cke = 1'b1;
            end
        end
        @(negedge s_img);
        in_valid     = 1'b0;
        in_row_first = 1'b0;
        in_col_first = 1'b0;
        cke          = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // reference queue and checks
    // ------------------------------------------------------------------
    always @(posedge s_img) begin
        prev_cke   <= cke;
        prev_valid <= out_valid;
        prev_data  <= out_data;
        if (rst) begin
            exp_q.delete();
            stamp_q.delete();
            head_valid <= 1'b0;
            en_cycle   <= 0;
        end else if (cke) begin
            // the visible beat is replaced on this edge
            if (out_valid && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
            if (in_valid) begin
                exp_q.push_back(pend_beat);
                stamp_q.push_back(en_cycle);
            end
            en_cycle <= en_cycle + 1;
            head_valid <= (exp_q.size() > 0);
            if (exp_q.size() > 0) begin
                head_beat  <= exp_q[0];
                head_stamp <= stamp_q[0];
            end
        end
    end

    assert property (@(posedge s_img) disable iff (rst) out_valid |-> head_valid)
        else stop_on_error("output beat appeared with no pixel outstanding");

    assert property (@(posedge s_img) disable iff (rst) out_valid |-> out_data == head_beat[9:0])
        else stop_on_error($sformatf("Error at %0t: out_data got %0d expected %0d",
                                     $time, $sampled(out_data), $sampled(head_beat[9:0])));

    assert property (@(posedge s_img) disable iff (rst) out_valid |-> out_side == head_beat[15:10])
        else stop_on_error($sformatf("Error at %0t: out_side got %b expected %b",
                                     $time, $sampled(out_side), $sampled(head_beat[15:10])));

    assert property (@(posedge s_img) disable iff (rst)
            out_valid && cke |-> en_cycle == head_stamp + 3)
        else stop_on_error($sformatf("Error at %0t: latency got %0d expected 3",
                                     $time, $sampled(en_cycle) - $sampled(head_stamp)));

    assert property (@(posedge s_img) disable iff (rst)
            !prev_cke |-> out_data == prev_data)
        else stop_on_error($sformatf("Error at %0t: held out_data got %0d expected %0d",
                                     $time, $sampled(out_data), $sampled(prev_data)));

    assert property (@(posedge s_img) disable iff (rst)
            !prev_cke |-> out_valid == prev_valid)
        else stop_on_error($sformatf("Error at %0t: held out_valid got %0b expected %0b",
                                     $time, $sampled(out_valid), $sampled(prev_valid)));

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        int n;
        int ph;
        void'($urandom(32'hf1d3));
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        cke          = 1'b1;
        in_valid     = 1'b0;
        in_row_first = 1'b0;
        in_row_last  = 1'b0;
        in_col_first = 1'b0;
        in_col_last  = 1'b0;
        in_de        = 1'b0;
        in_user      = '0;
        in_data      = '0;
        pend_beat    = '0;
        m_en         = 1'b0;
        m_ph         = 2'd0;
        m_off        = '{default: 10'd0};
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            n++;
            @(negedge s_img);
        end
        if (rst !== 1'b0) stop_on_error("reset was never released");

        // registers read back with unused bits as zero
        apb_write(ADDR_CTRL, 32'hffff_ffff);
        check_read(ADDR_CTRL);
        set_offsets(1000, -111);
        for (n = 0; n < 4; n++) check_read(offset_addr(n));
        check_read(12'h014);
        apb_write(12'h020, 32'hffff_fffa);
        check_read(ADDR_CTRL);
        for (n = 0; n < 4; n++) check_read(offset_addr(n));

        // pass-through with enable clear
        apb_write(ADDR_CTRL, 32'h0);
        send_frame(1'b0, 1023);

        // each starting phase with distinct offsets
        set_offsets(37, 61);
        for (ph = 0; ph < 4; ph++) begin
            apb_write(ADDR_CTRL, 32'(ph * 2 + 1));
            send_frame(1'b0, 1023);
        end

        // offsets above most samples drive the clamp at zero
        set_offsets(300, 200);
        send_frame(1'b0, 600);

        // mid-frame update stays out of the running frame
        fork
            send_frame(1'b0, 1023);
            begin
                repeat (10) @(negedge s_img);
                set_offsets(5, 90);
                apb_write(ADDR_CTRL, 32'h3);
            end
        join
        send_frame(1'b0, 1023);

        repeat (4) send_frame(1'b1, 1023);

        n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            n++;
            @(negedge s_img);
        end
        if (exp_q.size() != 0) begin
            stop_on_error("pixels still outstanding after the last frame");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/blc_clk_gen.sv
// ----------------------------------------------------------------------
// clock and reset for the testbench, 8 ns period
// reset is held for two rising edges, released on a falling edge
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blc_clk_gen (
    output logic s_img,
    output logic rst
);

    initial begin
        s_img = 1'b0;
        forever #4 s_img = ~s_img;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge s_img);
        @(negedge s_img);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/bayer_blc_core.sv
// ----------------------------------------------------------------------
// three stage black level pipeline: phase tracking, offset subtract,
// clamp. Latency is 3 cke-enabled clocks, cke low holds every stage.
// frame_start is combinational so the shadow set updates on the edge
// that accepts the first pixel; the phase is kept relative to the
// frame start and combined with shadow_phase in stage 1
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bayer_blc_core
    import bayer_blc_pkg::*;
(
    input  var logic                   s_img,
    input  var logic                   rst,
    input  var logic                   cke,

    input  var logic                   in_valid,
    input  var logic                   in_row_first,
    input  var logic                   in_row_last,
    input  var logic                   in_col_first,
    input  var logic                   in_col_last,
    input  var logic                   in_de,
    input  var logic [USER_BITS-1:0]   in_user,
    input  var logic [PIX_BITS-1:0]    in_data,

    input  var logic                   shadow_enable,
    input  var logic [PHASE_BITS-1:0]  shadow_phase,
    input  var logic [OFFSET_BITS-1:0] shadow_offset0,
    input  var logic [OFFSET_BITS-1:0] shadow_offset1,
    input  var logic [OFFSET_BITS-1:0] shadow_offset2,
    input  var logic [OFFSET_BITS-1:0] shadow_offset3,

    output logic                       frame_start,

    output logic                       out_valid,
    output logic                       out_row_first,
    output logic                       out_row_last,
    output logic                       out_col_first,
    output logic                       out_col_last,
    output logic                       out_de,
    output logic     [USER_BITS-1:0]   out_user,
    output logic     [OUT_BITS-1:0]    out_data
);

    logic                          row_start;

    logic [PHASE_BITS-1:0]         st0_phase;
    logic                          st0_valid;
    logic [4:0]                    st0_flags;
    logic [USER_BITS-1:0]          st0_user;
    logic signed [CALC_BITS-1:0]   st0_data;

    logic [PHASE_BITS-1:0]         site;
    logic [OFFSET_BITS-1:0]        sel_offset;
    logic signed [CALC_BITS-1:0]   sel_offset_w;

    logic                          st1_valid;
    logic [4:0]                    st1_flags;
    logic [USER_BITS-1:0]          st1_user;
    logic signed [CALC_BITS-1:0]   st1_data;

    logic                          st2_valid;
    logic [4:0]                    st2_flags;
    logic [USER_BITS-1:0]          st2_user;
    logic [OUT_BITS-1:0]           st2_data;

    assign row_start   = in_valid & in_col_first;
    assign frame_start = cke & row_start & in_row_first;

    // ------------------------------------------------------------------
    // stage 1 site select
    // ------------------------------------------------------------------
    // shadow_phase is stable for the frame once the first pixel is in st0
    assign site = st0_phase ^ shadow_phase;

    always_comb begin
        case (site)
            2'd0:    sel_offset = shadow_offset0;
            2'd1:    sel_offset = shadow_offset1;
            2'd2:    sel_offset = shadow_offset2;
            default: sel_offset = shadow_offset3;
        endcase
    end

    assign sel_offset_w = signed'({{(CALC_BITS-OFFSET_BITS){1'b0}}, sel_offset});

    // ------------------------------------------------------------------
    // control state
    // ------------------------------------------------------------------
    always_ff @(posedge s_img) begin
        if (rst) begin
            st0_phase <= '0;
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
            st2_valid <= 1'b0;
        end else if (cke) begin
            // column parity runs free, row parity steps per row
            st0_phase[0] <= ~st0_phase[0];
            if (row_start) begin
                st0_phase[0] <= 1'b0;
                if (in_row_first) begin
                    st0_phase[1] <= 1'b0;
                end else begin
                    st0_phase[1] <= ~st0_phase[1];
                end
            end
            st0_valid <= in_valid;
            st1_valid <= st0_valid;
            st2_valid <= st1_valid;
        end
    end

    // ------------------------------------------------------------------
    // payload
    // ------------------------------------------------------------------
    always_ff @(posedge s_img) begin
        if (cke) begin
            // stage 0
            st0_flags <= {in_row_first, in_row_last, in_col_first, in_col_last, in_de};
            st0_user  <= in_user;
            st0_data  <= signed'({{(CALC_BITS-PIX_BITS){1'b0}}, in_data});

            // stage 1
            st1_flags <= st0_flags;
            st1_user  <= st0_user;
            if (shadow_enable) begin
                st1_data <= st0_data - sel_offset_w;
            end else begin
                st1_data <= st0_data;
            end

            // stage 2, clamp to output range
            st2_flags <= st1_flags;
            st2_user  <= st1_user;
            if (st1_data < OUT_MIN) begin
                st2_data <= OUT_BITS'(OUT_MIN);
            end else if (st1_data > OUT_MAX) begin
                st2_data <= OUT_BITS'(OUT_MAX);
            end else begin
                st2_data <= st1_data[OUT_BITS-1:0];
            end
        end
    end

    assign out_valid     = st2_valid;
    assign out_row_first = st2_flags[4];
    assign out_row_last  = st2_flags[3];
    assign out_col_first = st2_flags[2];
    assign out_col_last  = st2_flags[1];
    assign out_de        = st2_flags[0];
    assign out_user      = st2_user;
    assign out_data      = st2_data;

endmodule

`default_nettype wire

//--- hw/bayer_blc_pkg.sv
// ----------------------------------------------------------------------
// shared widths, clamp limits and APB register map for the Bayer black
// level correction block. All widths are fixed here; the output is
// unsigned, so only the clamp at zero can act
// ----------------------------------------------------------------------

`default_nettype none

package bayer_blc_pkg;

    // pixel path widths
    localparam int PIX_BITS    = 10;
    localparam int OUT_BITS    = 10;
    localparam int OFFSET_BITS = 10;
    localparam int USER_BITS   = 1;
    localparam int PHASE_BITS  = 2;

    // signed working width, holds sample minus offset
    localparam int CALC_BITS   = 12;

    localparam int OUT_MAX     = 1023;
    localparam int OUT_MIN     = 0;

    // APB
    localparam int APB_ADDR_BITS = 12;
    localparam int APB_DATA_BITS = 32;

    // ------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------
    // ctrl bit 0 enable, bits 2:1 starting phase
    localparam logic [APB_ADDR_BITS-1:0] ADDR_CTRL    = 12'h000;
    // offset index is the phase, bit 1 row parity, bit 0 column parity
    localparam logic [APB_ADDR_BITS-1:0] ADDR_OFFSET0 = 12'h004;
    localparam logic [APB_ADDR_BITS-1:0] ADDR_OFFSET1 = 12'h008;
    localparam logic [APB_ADDR_BITS-1:0] ADDR_OFFSET2 = 12'h00c;
    localparam logic [APB_ADDR_BITS-1:0] ADDR_OFFSET3 = 12'h010;

endpackage

`default_nettype wire

//--- hw/bayer_blc_regs.sv
// ----------------------------------------------------------------------
// APB slave for the black level settings, no wait states (pready tied
// high). Live registers are written by software; the shadow set seen
// by the core is refreshed only on frame_start. Unmapped addresses
// return zero with pslverr during the access cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bayer_blc_regs
    import bayer_blc_pkg::*;
(
    input  var logic                     s_img,
    input  var logic                     rst,

    input  var logic [APB_ADDR_BITS-1:0] paddr,
    input  var logic                     psel,
    input  var logic                     penable,
    input  var logic                     pwrite,
    input  var logic [APB_DATA_BITS-1:0] pwdata,
    output logic     [APB_DATA_BITS-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,

    input  var logic                     frame_start,

    output logic                         shadow_enable,
    output logic     [PHASE_BITS-1:0]    shadow_phase,
    output logic     [OFFSET_BITS-1:0]   shadow_offset0,
    output logic     [OFFSET_BITS-1:0]   shadow_offset1,
    output logic     [OFFSET_BITS-1:0]   shadow_offset2,
    output logic     [OFFSET_BITS-1:0]   shadow_offset3
);

    logic                   live_enable;
    logic [PHASE_BITS-1:0]  live_phase;
    logic [OFFSET_BITS-1:0] live_offset0;
    logic [OFFSET_BITS-1:0] live_offset1;
    logic [OFFSET_BITS-1:0] live_offset2;
    logic [OFFSET_BITS-1:0] live_offset3;

    logic                   access;
    logic                   mapped;
    logic                   wr_en;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------
    assign access = psel & penable;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            ADDR_CTRL: begin
                prdata[0]              = live_enable;
                prdata[PHASE_BITS:1]   = live_phase;
            end
            ADDR_OFFSET0: prdata[OFFSET_BITS-1:0] = live_offset0;
            ADDR_OFFSET1: prdata[OFFSET_BITS-1:0] = live_offset1;
            ADDR_OFFSET2: prdata[OFFSET_BITS-1:0] = live_offset2;
            ADDR_OFFSET3: prdata[OFFSET_BITS-1:0] = live_offset3;
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;
    assign wr_en   = access & pwrite & mapped;

    // ------------------------------------------------------------------
    // live registers
    // ------------------------------------------------------------------
    always_ff @(posedge s_img) begin
        if (rst) begin
            live_enable  <= 1'b0;
            live_phase   <= '0;
            live_offset0 <= '0;
            live_offset1 <= '0;
            live_offset2 <= '0;
            live_offset3 <= '0;
        end else if (wr_en) begin
            case (paddr)
                ADDR_CTRL: begin
                    live_enable <= pwdata[0];
                    live_phase  <= pwdata[PHASE_BITS:1];
                end
                ADDR_OFFSET0: live_offset0 <= pwdata[OFFSET_BITS-1:0];
                ADDR_OFFSET1: live_offset1 <= pwdata[OFFSET_BITS-1:0];
                ADDR_OFFSET2: live_offset2 <= pwdata[OFFSET_BITS-1:0];
                ADDR_OFFSET3: live_offset3 <= pwdata[OFFSET_BITS-1:0];
                default: begin
                    live_enable <= live_enable;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // shadow set, frozen for the whole frame
    // ------------------------------------------------------------------
    always_ff @(posedge s_img) begin
        if (rst) begin
            shadow_enable  <= 1'b0;
            shadow_phase   <= '0;
            shadow_offset0 <= '0;
            shadow_offset1 <= '0;
            shadow_offset2 <= '0;
            shadow_offset3 <= '0;
        end else if (frame_start) begin
            shadow_enable  <= live_enable;
            shadow_phase   <= live_phase;
            shadow_offset0 <= live_offset0;
            shadow_offset1 <= live_offset1;
            shadow_offset2 <= live_offset2;
            shadow_offset3 <= live_offset3;
        end
    end

endmodule

`default_nettype wire

//--- hw/bayer_blc_top.sv
// ----------------------------------------------------------------------
// black level correction subsystem: APB register block plus pixel core
// pixel latency 3 enabled clocks, APB transfers take 2 clocks
// new settings apply from the next frame start after the write
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bayer_blc_top
    import bayer_blc_pkg::*;
(
    input  var logic                     s_img,
    input  var logic                     rst,

    input  var logic [APB_ADDR_BITS-1:0] paddr,
    input  var logic                     psel,
    input  var logic                     penable,
    input  var logic                     pwrite,
    input  var logic [APB_DATA_BITS-1:0] pwdata,
    output logic     [APB_DATA_BITS-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,

    input  var logic                     cke,
    input  var logic                     in_valid,
    input  var logic                     in_row_first,
    input  var logic                     in_row_last,
    input  var logic                     in_col_first,
    input  var logic                     in_col_last,
    input  var logic                     in_de,
    input  var logic [USER_BITS-1:0]     in_user,
    input  var logic [PIX_BITS-1:0]      in_data,

    output logic                         out_valid,
    output logic                         out_row_first,
    output logic                         out_row_last,
    output logic                         out_col_first,
    output logic                         out_col_last,
    output logic                         out_de,
    output logic     [USER_BITS-1:0]     out_user,
    output logic     [OUT_BITS-1:0]      out_data
);

    logic                   frame_start;
    logic                   shadow_enable;
    logic [PHASE_BITS-1:0]  shadow_phase;
    logic [OFFSET_BITS-1:0] shadow_offset0;
    logic [OFFSET_BITS-1:0] shadow_offset1;
    logic [OFFSET_BITS-1:0] shadow_offset2;
    logic [OFFSET_BITS-1:0] shadow_offset3;

    bayer_blc_regs u_regs (
        .s_img          (s_img),
        .rst            (rst),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .frame_start    (frame_start),
        .shadow_enable  (shadow_enable),
        .shadow_phase   (shadow_phase),
        .shadow_offset0 (shadow_offset0),
        .shadow_offset1 (shadow_offset1),
        .shadow_offset2 (shadow_offset2),
        .shadow_offset3 (shadow_offset3)
    );

    bayer_blc_core u_core (
        .s_img          (s_img),
        .rst            (rst),
        .cke            (cke),
        .in_valid       (in_valid),
        .in_row_first   (in_row_first),
        .in_row_last    (in_row_last),
        .in_col_first   (in_col_first),
        .in_col_last    (in_col_last),
        .in_de          (in_de),
        .in_user        (in_user),
        .in_data        (in_data),
        .shadow_enable  (shadow_enable),
        .shadow_phase   (shadow_phase),
        .shadow_offset0 (shadow_offset0),
        .shadow_offset1 (shadow_offset1),
        .shadow_offset2 (shadow_offset2),
        .shadow_offset3 (shadow_offset3),
        .frame_start    (frame_start),
        .out_valid      (out_valid),
        .out_row_first  (out_row_first),
        .out_row_last   (out_row_last),
        .out_col_first  (out_col_first),
        .out_col_last   (out_col_last),
        .out_de         (out_de),
        .out_user       (out_user),
        .out_data       (out_data)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is nonzero when the build fails or the run stops on an error
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module bayer_blc_tb \
    -f bayer_blc_top.f -Mdir obj_dir -o sim_bayer_blc &&
./obj_dir/sim_bayer_blc || exit 1
